// File: src/split_merge_consts.svh
`ifndef SPLIT_MERGE_CONSTS_SVH
`define SPLIT_MERGE_CONSTS_SVH

////////////////////////////////
// buffer geometry
////////////////////////////////

`define SM_MEM_ADDR_BITS 10     // buffer address width
`define SM_BANK_DEPTH    128    // spacing of bank base addresses
`define SM_DW            128    // one complex word

////////////////////////////////
// pass timing and task limits
////////////////////////////////

// cycles from read start to write start, must equal the FPU latency
`define SM_WR_DELAY      12

`define SM_TW_COUNT      64     // twiddle reads per task
`define SM_MAX_STAGE     7      // highest FFT stage handled

`endif

// File: src/sm_task_pkg.sv
package sm_task_pkg;

    ////////////////////////////////
    // task word fields
    ////////////////////////////////

    typedef enum logic {
        op_split = 1'b0,    // runs the FPU in inverse mode
        op_merge = 1'b1     // runs the FPU in forward mode
    } sm_op_e;

    typedef enum logic {
        fpu_fft  = 1'b0,
        fpu_ifft = 1'b1
    } fpu_mode_e;

    typedef logic [2:0] sm_stage_t;  // FFT stage 0..7

    ////////////////////////////////
    // controller
    ////////////////////////////////

    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_run   = 2'd1,    // reading, write pass not started yet
        st_drain = 2'd2     // waiting for the last write
    } sm_state_e;

endpackage

// File: src/sm_mem_pkg.sv
`include "split_merge_consts.svh"

package sm_mem_pkg;

    // address into one data or twiddle buffer
    typedef logic [`SM_MEM_ADDR_BITS-1:0] mem_addr_t;

    // one complex word as stored in a bank
    typedef logic [`SM_DW-1:0] bank_data_t;

    // running twiddle index before the stage offset
    typedef logic [7:0] tw_idx_t;

endpackage

// File: src/sm_ctrl.sv
`timescale 1ns/10ps
`include "split_merge_consts.svh"

module sm_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  sm_task_pkg::sm_op_e    op,
    input  sm_task_pkg::sm_stage_t stage,
    input  logic                   wr_last,   // final write of the pass
    output logic                   rd_go,
    output logic                   wr_go,
    output sm_task_pkg::fpu_mode_e fpu_mode,
    output logic                   op_done
);

    sm_task_pkg::sm_state_e  state;
    logic [`SM_WR_DELAY-1:0] go_dly;   // rd_go travelling towards the write side
    logic                    accept;

    assign accept = start && (state == sm_task_pkg::st_idle);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= sm_task_pkg::st_idle;
        end else begin
            case (state)
                sm_task_pkg::st_idle: begin
                    if (accept) state <= sm_task_pkg::st_run;
                end
                sm_task_pkg::st_run: begin
                    if (wr_go) state <= sm_task_pkg::st_drain;
                end
                sm_task_pkg::st_drain: begin
                    if (wr_last) state <= sm_task_pkg::st_idle;
                end
                default: state <= sm_task_pkg::st_idle;
            endcase
        end
    end

    ////////////////////////////////
    // read and write start pulses
    ////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_go   <= 1'b0;
            go_dly  <= '0;
            op_done <= 1'b0;
        end else begin
            rd_go   <= accept;                               // one cycle after start
            go_dly  <= {go_dly[`SM_WR_DELAY-2:0], rd_go};    // match the FPU pipeline
            op_done <= wr_last;
        end
    end

    assign wr_go = go_dly[`SM_WR_DELAY-1];

    // mode is captured with the task and held until the next one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fpu_mode <= sm_task_pkg::fpu_fft;
        end else if (accept) begin
            fpu_mode <= (op == sm_task_pkg::op_split) ? sm_task_pkg::fpu_ifft
                                                      : sm_task_pkg::fpu_fft;
        end
    end

endmodule

// File: src/stage_addr_gen.sv
`timescale 1ns/10ps
`include "split_merge_consts.svh"

module stage_addr_gen (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   go,
    input  sm_task_pkg::sm_stage_t stage,
    output logic                   en,
    output logic                   last,
    output sm_mem_pkg::mem_addr_t  la0,
    output sm_mem_pkg::mem_addr_t  la1,
    output sm_mem_pkg::mem_addr_t  la2
);

    localparam int CNT_BITS = `SM_MAX_STAGE - 2;  // reversed field at the top stage
    localparam int LA_BITS  = `SM_MAX_STAGE - 1;  // B at the top stage

    logic [CNT_BITS-1:0] cnt;
    logic [CNT_BITS-1:0] last_cnt;
    logic [CNT_BITS-1:0] rev;
    logic [LA_BITS-1:0]  rev0;
    logic [LA_BITS-1:0]  rev1;
    logic [2:0]          rot;
    int unsigned         wid;      // B-1 bits of the reversed counter

    // rotate right by r over the low w bits, upper bits zero
    function automatic logic [LA_BITS-1:0] rotr(input logic [LA_BITS-1:0] x,
                                                input int unsigned w,
                                                input int unsigned r);
        logic [LA_BITS-1:0] y;
        y = '0;
        for (int unsigned j = 0; j < LA_BITS; j++) begin
            if (j < w) y[j] = x[(j + r) % w];
        end
        return y;
    endfunction

    ////////////////////////////////
    // access counter
    ////////////////////////////////

    always_comb begin
        if (stage < 3) last_cnt = '0;     // single access
        else last_cnt = CNT_BITS'((6'd1 << (stage - 3'd2)) - 6'd1);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en  <= 1'b0;
            cnt <= '0;
        end else if (go) begin
            en  <= 1'b1;
            cnt <= '0;
        end else if (en) begin
            if (cnt == last_cnt) en <= 1'b0;
            else cnt <= cnt + 1'b1;
        end
    end

    assign last = en && (cnt == last_cnt);

    ////////////////////////////////
    // logical addresses
    ////////////////////////////////

    always_comb begin
        case (stage)
            3'd3:    rot = 3'd1;
            3'd4:    rot = 3'd2;
            3'd5:    rot = 3'd3;
            3'd6:    rot = 3'd0;
            3'd7:    rot = 3'd1;
            default: rot = 3'd0;
        endcase
    end

    always_comb begin
        wid = (stage < 3) ? 0 : 32'(stage) - 32'd2;
        rev = '0;
        for (int unsigned j = 0; j < CNT_BITS; j++) begin
            if (j < wid) rev[j] = cnt[wid-1-j];   // bit reversal over wid bits
        end
        rev0 = LA_BITS'(rev);
        rev1 = rev0 | (LA_BITS'(1) << wid);       // leading one above the field
        if (stage < 3) begin
            la0 = sm_mem_pkg::mem_addr_t'(0);
            la1 = sm_mem_pkg::mem_addr_t'(1);
            la2 = sm_mem_pkg::mem_addr_t'(0);
        end else begin
            la0 = sm_mem_pkg::mem_addr_t'(rotr(rev0, wid + 1, rot));
            la1 = sm_mem_pkg::mem_addr_t'(rotr(rev1, wid + 1, rot));
            la2 = sm_mem_pkg::mem_addr_t'(rotr(rev0, wid, rot));  // 1-bit at stage 3
        end
    end

endmodule

// File: src/bank_addr_map.sv
`timescale 1ns/10ps
`include "split_merge_consts.svh"

module bank_addr_map #(
    parameter bit IS_WRITE = 1'b0
) (
    input  sm_task_pkg::sm_op_e   op,
    input  sm_mem_pkg::mem_addr_t la0,
    input  sm_mem_pkg::mem_addr_t la1,
    input  sm_mem_pkg::mem_addr_t la2,
    input  sm_mem_pkg::mem_addr_t base0,
    input  sm_mem_pkg::mem_addr_t base1,
    input  sm_mem_pkg::mem_addr_t base2,
    input  logic                  pos,          // buffer position bit
    output sm_mem_pkg::mem_addr_t bank_addr [4]
);

    localparam sm_mem_pkg::mem_addr_t DEPTH = sm_mem_pkg::mem_addr_t'(`SM_BANK_DEPTH);

    logic                  spread;      // one buffer spread over all four banks
    logic                  swap;
    sm_mem_pkg::mem_addr_t spread_base;
    sm_mem_pkg::mem_addr_t pair_base_lo;
    sm_mem_pkg::mem_addr_t pair_base_hi;

    // split read and merge write use the spread layout
    assign spread = (op == sm_task_pkg::op_split) ^ IS_WRITE;
    assign swap   = (spread ? ^la0 : ^la2) ^ pos;   // parity swap

    assign spread_base  = IS_WRITE ? base2 : base0;
    assign pair_base_lo = IS_WRITE ? base1 : base0;
    assign pair_base_hi = IS_WRITE ? base2 : base1;

    ////////////////////////////////
    // per bank address
    ////////////////////////////////

    for (genvar i = 0; i < 4; i++) begin : g_bank
        localparam logic [1:0] IDX = 2'(i);

        logic [1:0]            spread_slot;
        logic [1:0]            pair_slot;
        sm_mem_pkg::mem_addr_t spread_addr;
        sm_mem_pkg::mem_addr_t pair_addr;

        assign spread_slot = IDX + {swap, 1'b0};          // wraps mod 4
        assign pair_slot   = {swap ^ IDX[1], IDX[0]};

        assign spread_addr = spread_base
                           + sm_mem_pkg::mem_addr_t'(spread_slot) * DEPTH
                           + ((IDX[1] ? la1 : la0) >> 1);  // upper pair takes la1
        assign pair_addr   = (IDX[1] ? pair_base_hi : pair_base_lo)
                           + sm_mem_pkg::mem_addr_t'(pair_slot) * DEPTH
                           + (la2 >> 1);

        assign bank_addr[i] = spread ? spread_addr : pair_addr;
    end

endmodule

// File: src/twiddle_addr_gen.sv
`timescale 1ns/10ps
`include "split_merge_consts.svh"

module twiddle_addr_gen (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   rd_go,
    input  logic                   rd_en,
    input  sm_task_pkg::sm_stage_t stage,
    output logic                   tw_en,
    output sm_mem_pkg::mem_addr_t  tw_addr [2]
);

    localparam sm_mem_pkg::tw_idx_t TW_LAST = sm_mem_pkg::tw_idx_t'(`SM_TW_COUNT - 1);

    sm_mem_pkg::tw_idx_t   idx;
    sm_mem_pkg::tw_idx_t   idx_d1;
    sm_mem_pkg::tw_idx_t   idx_d2;
    sm_mem_pkg::tw_idx_t   offset;
    sm_mem_pkg::mem_addr_t tw_base;
    logic                  en_d1;

    // restarts with each read pass, parks at the last index
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) idx <= TW_LAST;
        else if (rd_go) idx <= '0;
        else if (rd_en && idx != TW_LAST) idx <= idx + 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en_d1 <= 1'b0;
            tw_en <= 1'b0;
        end else begin
            en_d1 <= rd_en;
            tw_en <= en_d1;     // two cycles behind the data banks
        end
    end

    always_ff @(posedge clk) begin
        idx_d1 <= idx;
        idx_d2 <= idx_d1;
    end

    always_comb begin
        case (stage)
            3'd0:    offset = 8'd0;
            3'd1:    offset = 8'd1;
            3'd2:    offset = 8'd2;
            3'd3:    offset = 8'd3;
            3'd4:    offset = 8'd5;
            3'd5:    offset = 8'd9;
            3'd6:    offset = 8'd17;
            default: offset = 8'd33;
        endcase
    end

    assign tw_base    = sm_mem_pkg::mem_addr_t'(idx_d2) + sm_mem_pkg::mem_addr_t'(offset);
    assign tw_addr[0] = tw_base;
    assign tw_addr[1] = tw_base + sm_mem_pkg::mem_addr_t'(`SM_BANK_DEPTH);  // second bank

endmodule

// File: src/split_merge_top.sv
`timescale 1ns/10ps

module split_merge_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  sm_task_pkg::sm_op_e     op,
    input  sm_task_pkg::sm_stage_t  stage,
    input  sm_mem_pkg::mem_addr_t   base0,
    input  sm_mem_pkg::mem_addr_t   base1,
    input  sm_mem_pkg::mem_addr_t   base2,
    input  logic                    in_pos,
    input  logic                    out_pos,
    output logic                    rd_en,
    output sm_mem_pkg::mem_addr_t   rd_addr [4],
    input  sm_mem_pkg::bank_data_t  rd_data [4],
    output logic                    tw_en,
    output sm_mem_pkg::mem_addr_t   tw_addr [2],
    input  sm_mem_pkg::bank_data_t  tw_data [2],
    output logic                    wr_en,
    output sm_mem_pkg::mem_addr_t   wr_addr [4],
    output sm_mem_pkg::bank_data_t  wr_data [4],
    output sm_task_pkg::fpu_mode_e  fpu_mode,
    output sm_mem_pkg::bank_data_t  fpu_opnd [6],
    input  sm_mem_pkg::bank_data_t  fpu_res [4],
    output logic                    op_done
);

    logic                  rd_go;
    logic                  wr_go;
    logic                  wr_last;
    sm_mem_pkg::mem_addr_t rd_la0, rd_la1, rd_la2;
    sm_mem_pkg::mem_addr_t wr_la0, wr_la1, wr_la2;

    sm_ctrl u_ctrl (
        .clk, .rst_n, .start, .op, .stage,
        .wr_last (wr_last),
        .rd_go   (rd_go),
        .wr_go   (wr_go),
        .fpu_mode(fpu_mode),
        .op_done (op_done)
    );

    ////////////////////////////////
    // read side
    ////////////////////////////////

    stage_addr_gen rd_agen (
        .clk, .rst_n, .stage,
        .go  (rd_go),
        .en  (rd_en),
        .last(),                // pass end comes from the write side
        .la0 (rd_la0), .la1(rd_la1), .la2(rd_la2)
    );

    bank_addr_map #(.IS_WRITE(1'b0)) u_rd_map (
        .op, .base0, .base1, .base2,
        .la0(rd_la0), .la1(rd_la1), .la2(rd_la2),
        .pos      (in_pos),
        .bank_addr(rd_addr)
    );

    twiddle_addr_gen u_tw_gen (
        .clk, .rst_n, .stage,
        .rd_go  (rd_go),
        .rd_en  (rd_en),
        .tw_en  (tw_en),
        .tw_addr(tw_addr)
    );

    ////////////////////////////////
    // write side
    ////////////////////////////////

    stage_addr_gen wr_agen (
        .clk, .rst_n, .stage,
        .go  (wr_go),
        .en  (wr_en),
        .last(wr_last),
        .la0 (wr_la0), .la1(wr_la1), .la2(wr_la2)
    );

    bank_addr_map #(.IS_WRITE(1'b1)) u_wr_map (
        .op, .base0, .base1, .base2,
        .la0(wr_la0), .la1(wr_la1), .la2(wr_la2),
        .pos      (out_pos),
        .bank_addr(wr_addr)
    );

    // data passes straight between banks and the FPU
    for (genvar i = 0; i < 4; i++) begin : g_data
        assign fpu_opnd[i] = rd_data[i];
        assign wr_data[i]  = fpu_res[i];
    end

    assign fpu_opnd[4] = tw_data[0];    // twiddle operands last
    assign fpu_opnd[5] = tw_data[1];

endmodule

// File: verif/tb_split_merge.sv
`timescale 1ns/10ps
`include "split_merge_consts.svh"

module tb_split_merge;

    typedef struct {
        sm_task_pkg::sm_op_e    op;
        sm_task_pkg::sm_stage_t stage;
        sm_mem_pkg::mem_addr_t  base0, base1, base2;
        logic                   in_pos, out_pos;
        int                     exp_n;      // accesses per pass
    } task_row_t;

    localparam int NUM_ROWS       = 12;
    localparam int D              = `SM_BANK_DEPTH;
    localparam int WR_FIRST       = 2 + `SM_WR_DELAY;
    localparam int TIMEOUT_CYCLES = 20 + NUM_ROWS * (2 * `SM_TW_COUNT + `SM_WR_DELAY + 10);

    logic                   clk, rst_n, start, in_pos, out_pos;
    sm_task_pkg::sm_op_e    op;
    sm_task_pkg::sm_stage_t stage;
    sm_mem_pkg::mem_addr_t  base0, base1, base2;
    logic                   rd_en, tw_en, wr_en, op_done;
    sm_mem_pkg::mem_addr_t  rd_addr [4];
    sm_mem_pkg::mem_addr_t  wr_addr [4];
    sm_mem_pkg::mem_addr_t  tw_addr [2];
    sm_mem_pkg::bank_data_t rd_data [4];
    sm_mem_pkg::bank_data_t tw_data [2];
    sm_mem_pkg::bank_data_t wr_data [4];
    sm_mem_pkg::bank_data_t fpu_opnd [6];
    sm_mem_pkg::bank_data_t fpu_res [4];
    sm_mem_pkg::bank_data_t fpu_pipe [`SM_WR_DELAY][4];   // behavioral FPU latency
    sm_task_pkg::fpu_mode_e fpu_mode;

    task_row_t   rows [NUM_ROWS];
    int          row_cnt = 0;
    int          checks = 0, errors = 0, tests_run = 0, tests_failed = 0;
    int          cycle_count = 0;

    split_merge_top i_split_merge_top (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;   // 8 ns period

    always @(posedge clk) begin
        for (int d = `SM_WR_DELAY - 1; d > 0; d--) fpu_pipe[d] <= fpu_pipe[d-1];
        for (int i = 0; i < 4; i++) fpu_pipe[0][i] <= rd_data[i];
    end

    always_comb begin
        for (int i = 0; i < 4; i++) fpu_res[i] = fpu_pipe[`SM_WR_DELAY-1][i];
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    //////////////////////////////
    // reference model
    //////////////////////////////

    function automatic int rotate_right(input int x, input int n, input int r);
        int mask;
        int rr;
        mask = (1 << n) - 1;
        rr   = r % n;
        if (rr == 0) return x & mask;
        return ((x >> rr) | (x << (n - rr))) & mask;
    endfunction

    function automatic int bit_reverse(input int x, input int w);
        int y;
        y = 0;
        for (int j = 0; j < w; j++) y = y | (((x >> j) & 1) << (w - 1 - j));
        return y;
    endfunction

    function automatic void logical_addr(input int s, input int k,
                                         output int la0, output int la1, output int la2);
        int b, w, r, rv;
        if (s < 3) begin
            la0 = 0;
            la1 = 1;
            la2 = 0;
        end else begin
            b  = s - 1;
            w  = b - 1;
            r  = (s == 3) ? 1 : (s == 4) ? 2 : (s == 5) ? 3 : (s == 6) ? 0 : 1;
            rv = bit_reverse(k, w);
            la2 = (s == 3) ? rv : rotate_right(rv, w, r);
            la0 = rotate_right(rv, b, r);
            la1 = rotate_right((1 << w) | rv, b, r);
        end
    endfunction

    function automatic int ref_bank_addr(input task_row_t t, input bit is_wr,
                                         input int k, input int i);
        int la0, la1, la2, h, l, sw, pos, a;
        int bases [3];
        logical_addr(int'(t.stage), k, la0, la1, la2);
        bases = '{int'(t.base0), int'(t.base1), int'(t.base2)};
        h   = i / 2;
        l   = i % 2;
        pos = is_wr ? int'(t.out_pos) : int'(t.in_pos);
        if ((t.op == sm_task_pkg::op_split) != is_wr) begin  // spread over four banks
            sw = ($countones(la0) % 2) ^ pos;
            a  = bases[is_wr ? 2 : 0] + ((i + 2 * sw) % 4) * D + (h ? la1 : la0) / 2;
        end else begin
            sw = ($countones(la2) % 2) ^ pos;
            a  = bases[is_wr ? h + 1 : h] + (2 * (sw ^ h) + l) * D + la2 / 2;
        end
        return a % (1 << `SM_MEM_ADDR_BITS);
    endfunction

    function automatic int tw_offset(input int s);
        int offs [8];
        offs = '{0, 1, 2, 3, 5, 9, 17, 33};
        return offs[s];
    endfunction

    //////////////////////////////
    // checking helpers
    //////////////////////////////

    task automatic expect_value(input int got, input int exp, input string what);
        checks++;
        assert (got == exp) else begin
            $display("ERROR @%0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic expect_true(input bit ok, input string what);
        checks++;
        assert (ok) else begin
            $display("ERROR @%0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic add_row(input sm_task_pkg::sm_op_e o, input int s, input int b0,
                           input int b1, input int b2, input bit ip, input bit opos,
                           input int n);
        rows[row_cnt] = '{o, sm_task_pkg::sm_stage_t'(s), sm_mem_pkg::mem_addr_t'(b0),
                          sm_mem_pkg::mem_addr_t'(b1), sm_mem_pkg::mem_addr_t'(b2),
                          ip, opos, n};
        row_cnt++;
    endtask

    task automatic drive_random_data();
        for (int i = 0; i < 4; i++) rd_data[i] = {$urandom, $urandom, $urandom, $urandom};
        for (int i = 0; i < 2; i++) tw_data[i] = {$urandom, $urandom, $urandom, $urandom};
    endtask

    task automatic check_idle(input int cycles);
        int errs_before;
        errs_before = errors;
        repeat (cycles) begin
            @(negedge clk);
            expect_true(!rd_en && !wr_en && !tw_en && !op_done, "activity without a start");
        end
        tests_run++;
        if (errors != errs_before) tests_failed++;
        $display("test idle after reset: %s", (errors == errs_before) ? "ok" : "FAIL");
    endtask

    task automatic run_task(input int idx);
        task_row_t              t;
        int                     cyc, n, errs_before, rd_cnt, wr_cnt, done_cnt, done_cyc, ta;
        sm_task_pkg::fpu_mode_e exp_mode;
        t = rows[idx];
        n = t.exp_n;
        errs_before = errors;
        exp_mode = (t.op == sm_task_pkg::op_split) ? sm_task_pkg::fpu_ifft
                                                   : sm_task_pkg::fpu_fft;
        @(negedge clk);
        op      = t.op;
        stage   = t.stage;
        in_pos  = t.in_pos;
        out_pos = t.out_pos;
        base0   = t.base0;
        base1   = t.base1;
        base2   = t.base2;
        start   = 1'b1;
        cyc      = 0;
        rd_cnt   = 0;
        wr_cnt   = 0;
        done_cnt = 0;
        done_cyc = -1;
        while (done_cyc < 0 || cyc < done_cyc + 3) begin
            @(negedge clk);
            cyc++;
            expect_true(rd_en == (cyc >= 2 && cyc < 2 + n), $sformatf("rd_en at cycle %0d", cyc));
            expect_true(tw_en == (cyc >= 4 && cyc < 4 + n), $sformatf("tw_en at cycle %0d", cyc));
            expect_true(wr_en == (cyc >= WR_FIRST && cyc < WR_FIRST + n),
                        $sformatf("wr_en at cycle %0d", cyc));
            expect_true(op_done == (cyc == WR_FIRST + n),
                        $sformatf("op_done at cycle %0d", cyc));
            expect_true(fpu_mode == exp_mode, "fpu_mode wrong for the task op");
            for (int i = 0; i < 4; i++) begin
                expect_true(fpu_opnd[i] == rd_data[i], $sformatf("fpu_opnd[%0d] routing", i));
                if (rd_en) expect_value(int'(rd_addr[i]), ref_bank_addr(t, 1'b0, cyc - 2, i),
                                        $sformatf("rd_addr[%0d] cycle %0d", i, cyc));
                if (wr_en) begin
                    expect_value(int'(wr_addr[i]), ref_bank_addr(t, 1'b1, cyc - WR_FIRST, i),
                                 $sformatf("wr_addr[%0d] cycle %0d", i, cyc));
                    expect_true(wr_data[i] == fpu_res[i], $sformatf("wr_data[%0d] routing", i));
                end
            end
            expect_true(fpu_opnd[4] == tw_data[0] && fpu_opnd[5] == tw_data[1],
                        "twiddle operand routing");
            if (tw_en) begin
                ta = (cyc - 4) + tw_offset(int'(t.stage));
                expect_value(int'(tw_addr[0]), ta, "tw_addr[0]");
                expect_value(int'(tw_addr[1]), ta + D, "tw_addr[1]");
            end
            rd_cnt   += int'(rd_en);
            wr_cnt   += int'(wr_en);
            done_cnt += int'(op_done);
            if (op_done && done_cyc < 0) done_cyc = cyc;
            start = (cyc == 5);     // second start lands in the busy window
            drive_random_data();
        end
        expect_value(rd_cnt, n, "read accesses per task");
        expect_value(wr_cnt, n, "write accesses per task");
        expect_value(done_cnt, 1, "op_done pulses per task");
        tests_run++;
        if (errors != errs_before) tests_failed++;
        $display("test %0d %s stage %0d in_pos %0d out_pos %0d: %s", idx, t.op.name(),
                 t.stage, t.in_pos, t.out_pos, (errors == errs_before) ? "ok" : "FAIL");
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        void'($urandom(83005));
        rst_n   = 1'b0;
        start   = 1'b0;
        op      = sm_task_pkg::op_split;
        stage   = '0;
        base0   = '0;
        base1   = '0;
        base2   = '0;
        in_pos  = 1'b0;
        out_pos = 1'b0;
        for (int i = 0; i < 4; i++) rd_data[i] = '0;
        for (int i = 0; i < 2; i++) tw_data[i] = '0;
        for (int d = 0; d < `SM_WR_DELAY; d++) begin
            for (int i = 0; i < 4; i++) fpu_pipe[d][i] = '0;
        end

        add_row(sm_task_pkg::op_split, 0, 0,   256, 512, 1'b0, 1'b0, 1);
        add_row(sm_task_pkg::op_split, 1, 64,  320, 576, 1'b0, 1'b1, 1);
        add_row(sm_task_pkg::op_split, 2, 128, 384, 640, 1'b1, 1'b0, 1);
        add_row(sm_task_pkg::op_split, 3, 0,   512, 768, 1'b1, 1'b1, 2);
        add_row(sm_task_pkg::op_split, 4, 512, 0,   256, 1'b0, 1'b0, 4);
        add_row(sm_task_pkg::op_split, 5, 256, 512, 896, 1'b0, 1'b1, 8);   // write wraps
        add_row(sm_task_pkg::op_split, 6, 0,   256, 512, 1'b1, 1'b0, 16);
        add_row(sm_task_pkg::op_split, 7, 768, 0,   512, 1'b1, 1'b1, 32);
        add_row(sm_task_pkg::op_merge, 2, 0,   256, 512, 1'b0, 1'b0, 1);
        add_row(sm_task_pkg::op_merge, 3, 256, 512, 0,   1'b0, 1'b1, 2);
        add_row(sm_task_pkg::op_merge, 5, 512, 768, 128, 1'b1, 1'b0, 8);
        add_row(sm_task_pkg::op_merge, 7, 0,   512, 640, 1'b1, 1'b1, 32);

        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        check_idle(10);
        for (int r = 0; r < NUM_ROWS; r++) run_task(r);

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: split_merge.f
+incdir+src
src/sm_task_pkg.sv
src/sm_mem_pkg.sv
src/sm_ctrl.sv
src/stage_addr_gen.sv
src/bank_addr_map.sv
src/twiddle_addr_gen.sv
src/split_merge_top.sv
verif/tb_split_merge.sv

// File: run.sh
#!/usr/bin/env bash
# Build the split/merge address engine testbench with Verilator and run it.
set -eo pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f split_merge.f --top-module tb_split_merge -o sim

./obj_dir/sim | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
    echo "run.sh: simulation passed"
else
    echo "run.sh: simulation failed, see sim.log"
    exit 1
fi
